// File: hw/soc_defs.svh
//**************************************************************************
// address map and RAM sizing of the data bus
// SOC_RAM_WAIT must be 1 or more, SOC_RAM_WORDS a power of two
//**************************************************************************
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// masks select the region, compare (addr & mask) against the base
`define SOC_RAM_BASE  32'h0000_0000
`define SOC_RAM_MASK  32'hFFFF_F000
`define SOC_RAM_WORDS 1024
`define SOC_RAM_WAIT  2

// 256-byte peripheral pages
`define SOC_GPIO_BASE 32'h1000_0000
`define SOC_TICK_BASE 32'h1000_1000
`define SOC_PAGE_MASK 32'hFFFF_FF00

`endif

// File: hw/bus_pkg.sv
//**************************************************************************
// data bus request and response types, one access in flight at a time
//**************************************************************************
`default_nettype none

package bus_pkg;

    // master request, same shape on every slave port
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic        rd;
        logic        wr;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        stall;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_GPIO,
        SEL_TICK,
        SEL_NONE
    } slave_sel_e;

    // byte lanes with be set take the new word
    function automatic logic [31:0] be_merge(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  be);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

// File: hw/periph_pkg.sv
//**************************************************************************
// register indices of the GPIO and ticker pages, RAM sequencer states
//**************************************************************************
`default_nettype none

package periph_pkg;

    // word index within the GPIO page, addr[3:2]
    typedef enum logic [1:0] {
        GPIO_OUT = 2'd0,
        GPIO_OE  = 2'd1,
        GPIO_IN  = 2'd2
    } gpio_reg_e;

    // word index within the ticker page, addr[3:2]
    typedef enum logic [1:0] {
        TICK_COUNT   = 2'd0,
        TICK_COMPARE = 2'd1,
        TICK_CTRL    = 2'd2
    } tick_reg_e;

    // bit positions in TICK_CTRL
    localparam int TICK_CTRL_EN  = 0;
    localparam int TICK_CTRL_IRQ = 1;

    typedef enum logic [1:0] {
        RAM_IDLE,
        RAM_WAIT,
        RAM_DONE
    } ram_state_e;

endpackage

`default_nettype wire

// File: hw/dbus.sv
//**************************************************************************
// data bus decoder, unmapped addresses read zero and drop writes
// the master must hold its request while stall is high
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "soc_defs.svh"

module dbus
    import bus_pkg::*;
(
    input  wire           clk,
    input  wire           reset_i,

    input  wire bus_req_t m_req_i,
    output bus_rsp_t      m_rsp_o,

    output bus_req_t      ram_req_o,
    input  wire bus_rsp_t ram_rsp_i,

    output bus_req_t      gpio_req_o,
    input  wire bus_rsp_t gpio_rsp_i,

    output bus_req_t      tick_req_o,
    input  wire bus_rsp_t tick_rsp_i
);

    slave_sel_e sel;

    always_comb begin
        if ((m_req_i.addr & `SOC_RAM_MASK) == `SOC_RAM_BASE) begin
            sel = SEL_RAM;
        end else if ((m_req_i.addr & `SOC_PAGE_MASK) == `SOC_GPIO_BASE) begin
            sel = SEL_GPIO;
        end else if ((m_req_i.addr & `SOC_PAGE_MASK) == `SOC_TICK_BASE) begin
            sel = SEL_TICK;
        end else begin
            sel = SEL_NONE;
        end
    end

    // strobes reach the selected slave only
    always_comb begin
        ram_req_o     = m_req_i;
        gpio_req_o    = m_req_i;
        tick_req_o    = m_req_i;
        ram_req_o.rd  = m_req_i.rd & (sel == SEL_RAM);
        ram_req_o.wr  = m_req_i.wr & (sel == SEL_RAM);
        gpio_req_o.rd = m_req_i.rd & (sel == SEL_GPIO);
        gpio_req_o.wr = m_req_i.wr & (sel == SEL_GPIO);
        tick_req_o.rd = m_req_i.rd & (sel == SEL_TICK);
        tick_req_o.wr = m_req_i.wr & (sel == SEL_TICK);
    end

    always_comb begin
        case (sel)
            SEL_RAM: begin
                m_rsp_o = ram_rsp_i;
            end
            SEL_GPIO: begin
                m_rsp_o = gpio_rsp_i;
            end
            SEL_TICK: begin
                m_rsp_o = tick_rsp_i;
            end
            default: begin
                // hole in the map
                m_rsp_o = '{rdata: 32'd0, stall: 1'b0};
            end
        endcase
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset_i)
        !(m_req_i.rd && m_req_i.wr));

    // master side of the handshake
    a_req_hold: assert property (@(posedge clk) disable iff (reset_i)
        m_rsp_o.stall |=> $stable(m_req_i));

    // a slave strobe only for an address inside that slave's region
    a_ram_quiet: assert property (@(posedge clk) disable iff (reset_i)
        (ram_req_o.rd || ram_req_o.wr)
        |-> ((m_req_i.addr & `SOC_RAM_MASK) == `SOC_RAM_BASE));

    a_gpio_quiet: assert property (@(posedge clk) disable iff (reset_i)
        (gpio_req_o.rd || gpio_req_o.wr)
        |-> ((m_req_i.addr & `SOC_PAGE_MASK) == `SOC_GPIO_BASE));

    a_tick_quiet: assert property (@(posedge clk) disable iff (reset_i)
        (tick_req_o.rd || tick_req_o.wr)
        |-> ((m_req_i.addr & `SOC_PAGE_MASK) == `SOC_TICK_BASE));

endmodule

`default_nettype wire

// File: hw/ram_slave.sv
//**************************************************************************
// word RAM, each access stalls SOC_RAM_WAIT cycles then completes
// address wraps modulo SOC_RAM_WORDS, contents are undefined after reset
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "soc_defs.svh"

module ram_slave
    import bus_pkg::*;
    import periph_pkg::*;
(
    input  wire           clk,
    input  wire           reset_i,
    input  wire bus_req_t req_i,
    output bus_rsp_t      rsp_o
);

    localparam int IDX_W = $clog2(`SOC_RAM_WORDS);
    localparam int CNT_W = $clog2(`SOC_RAM_WAIT + 1);

    ram_state_e       state_q;
    ram_state_e       state_d;
    logic [CNT_W-1:0] cnt_q;
    logic [31:0]      mem [`SOC_RAM_WORDS];
    logic [31:0]      rdata_q;
    logic [IDX_W-1:0] word_idx;
    logic             strobe;

    assign strobe   = req_i.rd | req_i.wr;
    assign word_idx = req_i.addr[IDX_W+1:2];

    always_comb begin
        state_d = state_q;
        case (state_q)
            RAM_IDLE: begin
                if (strobe) begin
                    state_d = (`SOC_RAM_WAIT == 1) ? RAM_DONE : RAM_WAIT;
                end
            end
            RAM_WAIT: begin
                if (!strobe) begin
                    state_d = RAM_IDLE;
                end else if (cnt_q == CNT_W'(`SOC_RAM_WAIT - 1)) begin
                    state_d = RAM_DONE;
                end
            end
            default: begin
                state_d = RAM_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= RAM_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            // first wait cycle is spent in idle
            if (state_q == RAM_IDLE) begin
                cnt_q <= CNT_W'(1);
            end else if (state_q == RAM_WAIT) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // read-first array, write lands at the completing edge
    always_ff @(posedge clk) begin
        rdata_q <= mem[word_idx];
        if (state_q == RAM_DONE && req_i.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.be[b]) begin
                    mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    assign rsp_o.rdata = rdata_q;
    assign rsp_o.stall = strobe && (state_q != RAM_DONE);

    a_stall_len: assert property (@(posedge clk) disable iff (reset_i)
        $rose(rsp_o.stall) |-> ##(`SOC_RAM_WAIT) !rsp_o.stall);

endmodule

`default_nettype wire

// File: hw/gpio_regs.sv
//**************************************************************************
// 16-bit GPIO, registers alias every 16 bytes within the page
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module gpio_regs
    import bus_pkg::*;
    import periph_pkg::*;
(
    input  wire           clk,
    input  wire           reset_i,
    input  wire bus_req_t req_i,
    output bus_rsp_t      rsp_o,
    input  wire [15:0]    gpio_in_i,
    output logic [15:0]   gpio_out_o,
    output logic [15:0]   gpio_oe_o
);

    gpio_reg_e   idx;
    logic [15:0] out_q;
    logic [15:0] oe_q;
    logic [15:0] in_meta_q;
    logic [15:0] in_sync_q;
    logic [31:0] out_merged;
    logic [31:0] oe_merged;

    assign idx        = gpio_reg_e'(req_i.addr[3:2]);
    assign out_merged = be_merge({16'd0, out_q}, req_i.wdata, req_i.be);
    assign oe_merged  = be_merge({16'd0, oe_q}, req_i.wdata, req_i.be);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_q <= '0;
            oe_q  <= '0;
        end else if (req_i.wr) begin
            if (idx == GPIO_OUT) begin
                out_q <= out_merged[15:0];
            end
            if (idx == GPIO_OE) begin
                oe_q <= oe_merged[15:0];
            end
        end
    end

    // two-flop synchronizer on the pins
    always_ff @(posedge clk) begin
        in_meta_q <= gpio_in_i;
        in_sync_q <= in_meta_q;
    end

    always_comb begin
        case (idx)
            GPIO_OUT: rsp_o.rdata = {16'd0, out_q};
            GPIO_OE:  rsp_o.rdata = {16'd0, oe_q};
            GPIO_IN:  rsp_o.rdata = {16'd0, in_sync_q};
            default:  rsp_o.rdata = 32'd0;
        endcase
    end

    assign rsp_o.stall = 1'b0;
    assign gpio_out_o  = out_q;
    assign gpio_oe_o   = oe_q;

endmodule

`default_nettype wire

// File: hw/ticker.sv
//**************************************************************************
// 32-bit ticker on the bus clock, irq stays set until cleared by software
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module ticker
    import bus_pkg::*;
    import periph_pkg::*;
(
    input  wire           clk,
    input  wire           reset_i,
    input  wire bus_req_t req_i,
    output bus_rsp_t      rsp_o,
    output logic          tick_irq_o
);

    tick_reg_e   idx;
    logic [31:0] count_q;
    logic [31:0] compare_q;
    logic        en_q;
    logic        irq_q;
    logic        wr_count;
    logic        wr_compare;
    logic        irq_clear;

    assign idx        = tick_reg_e'(req_i.addr[3:2]);
    assign wr_count   = req_i.wr && (idx == TICK_COUNT);
    assign wr_compare = req_i.wr && (idx == TICK_COMPARE);
    assign irq_clear  = req_i.wr && (idx == TICK_CTRL) && req_i.be[0]
                        && req_i.wdata[TICK_CTRL_IRQ];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q   <= '0;
            compare_q <= '0;
            en_q      <= 1'b0;
            irq_q     <= 1'b0;
        end else begin
            // bus write beats the increment
            if (wr_count) begin
                count_q <= be_merge(count_q, req_i.wdata, req_i.be);
            end else if (en_q) begin
                count_q <= count_q + 32'd1;
            end
            if (wr_compare) begin
                compare_q <= be_merge(compare_q, req_i.wdata, req_i.be);
            end
            if (req_i.wr && (idx == TICK_CTRL) && req_i.be[0]) begin
                en_q <= req_i.wdata[TICK_CTRL_EN];
            end
            // a new match wins over a clear in the same cycle
            if (en_q && (count_q == compare_q)) begin
                irq_q <= 1'b1;
            end else if (irq_clear) begin
                irq_q <= 1'b0;
            end
        end
    end

    always_comb begin
        case (idx)
            TICK_COUNT:   rsp_o.rdata = count_q;
            TICK_COMPARE: rsp_o.rdata = compare_q;
            TICK_CTRL:    rsp_o.rdata = {30'd0, irq_q, en_q};
            default:      rsp_o.rdata = 32'd0;
        endcase
    end

    assign rsp_o.stall = 1'b0;
    assign tick_irq_o  = irq_q;

endmodule

`default_nettype wire

// File: hw/soc_bus_top.sv
//**************************************************************************
// data bus with RAM, GPIO and ticker slaves, single clock domain
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top
    import bus_pkg::*;
(
    input  wire           clk,
    input  wire           reset_i,
    input  wire bus_req_t bus_req_i,
    output bus_rsp_t      bus_rsp_o,
    input  wire [15:0]    gpio_in_i,
    output logic [15:0]   gpio_out_o,
    output logic [15:0]   gpio_oe_o,
    output logic          tick_irq_o
);

    bus_req_t ram_req;
    bus_rsp_t ram_rsp;
    bus_req_t gpio_req;
    bus_rsp_t gpio_rsp;
    bus_req_t tick_req;
    bus_rsp_t tick_rsp;

    dbus u_dbus (
        .clk        (clk),
        .reset_i    (reset_i),
        .m_req_i    (bus_req_i),
        .m_rsp_o    (bus_rsp_o),
        .ram_req_o  (ram_req),
        .ram_rsp_i  (ram_rsp),
        .gpio_req_o (gpio_req),
        .gpio_rsp_i (gpio_rsp),
        .tick_req_o (tick_req),
        .tick_rsp_i (tick_rsp)
    );

    ram_slave u_ram (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (ram_req),
        .rsp_o   (ram_rsp)
    );

    gpio_regs u_gpio (
        .clk        (clk),
        .reset_i    (reset_i),
        .req_i      (gpio_req),
        .rsp_o      (gpio_rsp),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .gpio_oe_o  (gpio_oe_o)
    );

    ticker u_ticker (
        .clk        (clk),
        .reset_i    (reset_i),
        .req_i      (tick_req),
        .rsp_o      (tick_rsp),
        .tick_irq_o (tick_irq_o)
    );

endmodule

`default_nettype wire

// File: verification/tb_soc_bus.sv
//**************************************************************************
// bus master testbench, one access at a time, RAM addresses below 0x1000
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "soc_defs.svh"

module tb_soc_bus
    import bus_pkg::*;
    import periph_pkg::*;
();

    typedef enum logic [2:0] {K_WR, K_RD, K_RD_MIN, K_PIN_IN, K_PINS, K_IRQ} kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic [31:0] exp;
    } entry_t;

    logic        clk;
    logic        reset_i;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    logic [15:0] gpio_in;
    logic [15:0] gpio_out;
    logic [15:0] gpio_oe;
    logic        tick_irq;

    entry_t      tbl[$];
    logic [31:0] lfsr;
    logic [31:0] ram_model [`SOC_RAM_WORDS];
    logic [15:0] out_model;
    logic [15:0] oe_model;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 1000000;

    soc_bus_top u_dut (
        .clk        (clk),
        .reset_i    (reset_i),
        .bus_req_i  (bus_req),
        .bus_rsp_o  (bus_rsp),
        .gpio_in_i  (gpio_in),
        .gpio_out_o (gpio_out),
        .gpio_oe_o  (gpio_oe),
        .tick_irq_o (tick_irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: tests still running after %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] word;
        logic        lsb;
        word = '0;
        for (int i = 0; i < n; i++) begin
            lsb = lfsr[0];
            word[i] = lsb;
            lfsr = (lfsr >> 1) ^ (lsb ? 32'hD000_0001 : 32'h0);
        end
        return word;
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] lane_mask;
        lane_mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_word & ~lane_mask) | (new_word & lane_mask);
    endfunction

    function automatic entry_t make_entry(input kind_e k, input logic [31:0] a,
                                          input logic [31:0] w, input logic [3:0] be,
                                          input logic [31:0] exp);
        entry_t e;
        e.kind  = k;
        e.addr  = a;
        e.wdata = w;
        e.be    = be;
        e.exp   = exp;
        return e;
    endfunction

    function automatic bit is_ram(input logic [31:0] a);
        return (a & `SOC_RAM_MASK) == `SOC_RAM_BASE;
    endfunction

    function automatic int ram_index(input logic [31:0] a);
        return (a >> 2) % `SOC_RAM_WORDS;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [31:0] base, input int idx);
        return base + 32'(idx * 4);
    endfunction

    task automatic ram_write(input logic [31:0] a, input logic [31:0] w,
                             input logic [3:0] be);
        ram_model[ram_index(a)] = merge_lanes(ram_model[ram_index(a)], w, be);
        tbl.push_back(make_entry(K_WR, a, w, be, 32'd0));
    endtask

    task automatic build_table();
        logic [31:0] addrs [4];
        logic [31:0] w;
        logic [31:0] merged;
        logic [31:0] pins;
        logic [31:0] gpio_o;
        logic [31:0] gpio_e;
        logic [31:0] tick_c;
        addrs  = '{32'h0000_0000, 32'h0000_0124, 32'h0000_0800, 32'h0000_0FFC};
        gpio_o = reg_addr(`SOC_GPIO_BASE, GPIO_OUT);
        gpio_e = reg_addr(`SOC_GPIO_BASE, GPIO_OE);
        tick_c = reg_addr(`SOC_TICK_BASE, TICK_CTRL);
        tbl.push_back(make_entry(K_PINS, 32'd0, 32'd0, 4'h0, 32'd0));
        tbl.push_back(make_entry(K_IRQ, 32'd0, 32'd0, 4'h0, 32'd0));
        foreach (addrs[i]) begin
            ram_model[ram_index(addrs[i])] = 32'd0;
            ram_write(addrs[i], rand_bits(32), 4'hF);
        end
        // partial writes merge with the previous word
        ram_write(addrs[1], rand_bits(32), 4'b0101);
        ram_write(addrs[2], rand_bits(32), 4'b1000);
        foreach (addrs[i]) begin
            tbl.push_back(make_entry(K_RD, addrs[i], 32'd0, 4'h0, ram_model[ram_index(addrs[i])]));
        end
        w = rand_bits(16);
        out_model = w[15:0];
        w = rand_bits(16);
        oe_model = w[15:0];
        tbl.push_back(make_entry(K_WR, gpio_o, {16'd0, out_model}, 4'hF, 32'd0));
        tbl.push_back(make_entry(K_WR, gpio_e, {16'd0, oe_model}, 4'hF, 32'd0));
        tbl.push_back(make_entry(K_PINS, 32'd0, 32'd0, 4'h0, {oe_model, out_model}));
        w = rand_bits(32);
        merged = merge_lanes({16'd0, out_model}, w, 4'b0010);
        out_model = merged[15:0];
        tbl.push_back(make_entry(K_WR, gpio_o, w, 4'b0010, 32'd0));
        tbl.push_back(make_entry(K_RD, gpio_o, 32'd0, 4'h0, {16'd0, out_model}));
        tbl.push_back(make_entry(K_PINS, 32'd0, 32'd0, 4'h0, {oe_model, out_model}));
        pins = rand_bits(16);
        tbl.push_back(make_entry(K_PIN_IN, 32'd0, pins, 4'h0, 32'd0));
        tbl.push_back(make_entry(K_RD, reg_addr(`SOC_GPIO_BASE, GPIO_IN), 32'd0, 4'h0, pins));
        tbl.push_back(make_entry(K_WR, reg_addr(`SOC_GPIO_BASE, GPIO_IN), rand_bits(32),
                                 4'hF, 32'd0));
        tbl.push_back(make_entry(K_RD, reg_addr(`SOC_GPIO_BASE, GPIO_IN), 32'd0, 4'h0, pins));
        tbl.push_back(make_entry(K_RD, reg_addr(`SOC_GPIO_BASE, 3), 32'd0, 4'h0, 32'd0));
        // holes in the map
        tbl.push_back(make_entry(K_RD, 32'h2000_0000, 32'd0, 4'h0, 32'd0));
        tbl.push_back(make_entry(K_WR, 32'h2000_0000, rand_bits(32), 4'hF, 32'd0));
        tbl.push_back(make_entry(K_RD, 32'h0000_0000, 32'd0, 4'h0, ram_model[0]));
        tbl.push_back(make_entry(K_RD, gpio_e, 32'd0, 4'h0, {16'd0, oe_model}));
        tbl.push_back(make_entry(K_PINS, 32'd0, 32'd0, 4'h0, {oe_model, out_model}));
        // ticker: count 0, compare 20, enable, wait for irq, clear it
        tbl.push_back(make_entry(K_WR, reg_addr(`SOC_TICK_BASE, TICK_COUNT), 32'd0, 4'hF, 32'd0));
        tbl.push_back(make_entry(K_WR, reg_addr(`SOC_TICK_BASE, TICK_COMPARE), 32'd20, 4'hF,
                                 32'd0));
        tbl.push_back(make_entry(K_WR, tick_c, 32'd1, 4'h1, 32'd0));
        tbl.push_back(make_entry(K_IRQ, 32'd0, 32'd0, 4'h0, 32'd1));
        tbl.push_back(make_entry(K_RD_MIN, reg_addr(`SOC_TICK_BASE, TICK_COUNT), 32'd0, 4'h0,
                                 32'd20));
        tbl.push_back(make_entry(K_WR, tick_c, 32'd2, 4'h1, 32'd0));
        tbl.push_back(make_entry(K_RD, tick_c, 32'd0, 4'h0, 32'd0));
        tbl.push_back(make_entry(K_IRQ, 32'd0, 32'd0, 4'h0, 32'd0));
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // hold the request until a rising edge with stall low
    task automatic bus_access(input entry_t e, output logic [31:0] rdata,
                              output int stalls);
        bit done;
        @(negedge clk);
        bus_req.addr  = e.addr;
        bus_req.wdata = e.wdata;
        bus_req.be    = e.be;
        bus_req.rd    = (e.kind != K_WR);
        bus_req.wr    = (e.kind == K_WR);
        stalls = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (bus_rsp.stall) begin
                stalls++;
            end else begin
                rdata = bus_rsp.rdata;
                done  = 1'b1;
            end
        end
        @(negedge clk);
        bus_req.rd = 1'b0;
        bus_req.wr = 1'b0;
    endtask

    task automatic run_entry(input entry_t e);
        logic [31:0] rdata;
        int          stalls;
        int          waited;
        case (e.kind)
            K_PIN_IN: begin
                @(negedge clk);
                gpio_in = e.wdata[15:0];
                repeat (3) @(negedge clk);
            end
            K_PINS: begin
                @(negedge clk);
                check_value({16'd0, gpio_out}, {16'd0, e.exp[15:0]}, "gpio_out_o");
                check_value({16'd0, gpio_oe}, {16'd0, e.exp[31:16]}, "gpio_oe_o");
            end
            K_IRQ: begin
                waited = 0;
                while (tick_irq !== e.exp[0] && waited < 40) begin
                    @(posedge clk);
                    waited++;
                end
                checks++;
                assert (tick_irq === e.exp[0]) else begin
                    $display("tick_irq_o did not go to %0b within 40 cycles", e.exp[0]);
                    errors++;
                end
            end
            default: begin
                bus_access(e, rdata, stalls);
                check_value(stalls, is_ram(e.addr) ? `SOC_RAM_WAIT : 0, "stall cycles");
                if (e.kind == K_RD) begin
                    check_value(rdata, e.exp, "read data");
                end else if (e.kind == K_RD_MIN) begin
                    checks++;
                    assert (rdata >= e.exp) else begin
                        $display("FAILED %0t: count %0d below %0d", $time, rdata, e.exp);
                        errors++;
                    end
                end
            end
        endcase
    endtask

    initial begin
        int err_before;
        reset_i = 1'b1;
        bus_req = '0;
        gpio_in = 16'd0;
        lfsr    = 32'he9a4;
        build_table();
        limit = tbl.size() * (`SOC_RAM_WAIT + 3) + 400 + 8;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        foreach (tbl[i]) begin
            err_before = errors;
            run_entry(tbl[i]);
            $display("test %0d %s addr %h: %s", i, tbl[i].kind.name(), tbl[i].addr,
                     (errors == err_before) ? "ok" : "errors");
        end
        $display("%0d tests, %0d checks, %0d errors", tbl.size(), checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/bus_pkg.sv
hw/periph_pkg.sv
hw/dbus.sv
hw/ram_slave.sv
hw/gpio_regs.sv
hw/ticker.sv
hw/soc_bus_top.sv
verification/tb_soc_bus.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_soc_bus
out=$(./obj_dir/Vtb_soc_bus)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
